// File: rtl/lc3b_bus_pkg.sv
package lc3b_bus_pkg;

    localparam int LINE_W = 128;  // one cache line
    localparam int ADR_W  = 12;   // line address
    localparam int SEL_W  = LINE_W / 8;  // one select per byte

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [ADR_W-1:0]  adr_t;
    typedef logic [SEL_W-1:0]  sel_t;

    // master to slave, 159 bits
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        sel_t  sel;
        adr_t  adr;
        line_t dat;
    } wb_req_t;

    // slave to master, 130 bits
    typedef struct packed {
        logic  ack;
        logic  rty;
        line_t dat;
    } wb_rsp_t;

    localparam int MEM_DEPTH   = 256;  // lines held by the memory
    localparam int MEM_IDX_W   = $clog2(MEM_DEPTH);  // low address bits used as index
    localparam int MEM_LATENCY = 3;    // accept to ack, in cycles

    // latency counter, loaded on accept and run down to zero
    localparam int MEM_CNT_W = $clog2(MEM_LATENCY + 1);
    localparam logic [MEM_CNT_W-1:0] MEM_CNT_LOAD = MEM_CNT_W'(MEM_LATENCY - 1);

endpackage : lc3b_bus_pkg

// File: rtl/lc3b_arb_pkg.sv
package lc3b_arb_pkg;

    localparam int N_PORTS = 2;  // icache and dcache

    // who currently holds the memory bus
    typedef enum logic [1:0] {
        OWNER_NONE  = 2'd0,
        OWNER_PORT0 = 2'd1,  // instruction cache
        OWNER_PORT1 = 2'd2   // data cache
    } owner_e;

endpackage : lc3b_arb_pkg

// File: rtl/bus_barrier.sv
`timescale 1ns/1ps

// single register stage between a bus source and its sink
module bus_barrier #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     i_arst_n,
    input  payload_t i_d,
    output payload_t o_q
);

    payload_t q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            q <= '0;  // no cyc, no ack out of reset
        end else begin
            q <= i_d;
        end
    end

    assign o_q = q;

endmodule : bus_barrier

// File: rtl/cache_arbiter.sv
`timescale 1ns/1ps

module cache_arbiter (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  lc3b_bus_pkg::wb_req_t i_raw_req0,  // before barrier
    input  lc3b_bus_pkg::wb_req_t i_raw_req1,
    input  lc3b_bus_pkg::wb_req_t i_reg_req0,  // after barrier
    input  lc3b_bus_pkg::wb_req_t i_reg_req1,
    input  lc3b_bus_pkg::wb_rsp_t i_mem_rsp,   // registered memory response
    output lc3b_bus_pkg::wb_req_t o_mem_req,
    output lc3b_bus_pkg::wb_rsp_t o_rsp0,
    output lc3b_bus_pkg::wb_rsp_t o_rsp1
);

    lc3b_arb_pkg::owner_e owner;
    lc3b_arb_pkg::owner_e next_owner;

    lc3b_bus_pkg::wb_req_t raw_req [lc3b_arb_pkg::N_PORTS];
    lc3b_bus_pkg::wb_req_t reg_req [lc3b_arb_pkg::N_PORTS];
    lc3b_bus_pkg::wb_rsp_t rsp     [lc3b_arb_pkg::N_PORTS];

    logic [lc3b_arb_pkg::N_PORTS-1:0] own;    // port holds the bus
    logic [lc3b_arb_pkg::N_PORTS-1:0] grant;  // port wins from idle this cycle

    assign raw_req[0] = i_raw_req0;
    assign raw_req[1] = i_raw_req1;
    assign reg_req[0] = i_reg_req0;
    assign reg_req[1] = i_reg_req1;

    assign own[0] = (owner == lc3b_arb_pkg::OWNER_PORT0);
    assign own[1] = (owner == lc3b_arb_pkg::OWNER_PORT1);

    // fixed priority, port 0 first, only when the bus is free
    assign grant[0] = (owner == lc3b_arb_pkg::OWNER_NONE) & raw_req[0].cyc;
    assign grant[1] = (owner == lc3b_arb_pkg::OWNER_NONE) & ~raw_req[0].cyc
                    & raw_req[1].cyc;

    always_comb begin
        next_owner = owner;
        case (owner)
            lc3b_arb_pkg::OWNER_NONE: begin
                if (raw_req[0].cyc) begin
                    next_owner = lc3b_arb_pkg::OWNER_PORT0;
                end else if (raw_req[1].cyc) begin
                    next_owner = lc3b_arb_pkg::OWNER_PORT1;
                end
            end
            lc3b_arb_pkg::OWNER_PORT0: begin
                if (!raw_req[0].cyc) begin  // owner lets go
                    next_owner = raw_req[1].cyc ? lc3b_arb_pkg::OWNER_PORT1
                                                : lc3b_arb_pkg::OWNER_NONE;
                end
            end
            lc3b_arb_pkg::OWNER_PORT1: begin
                if (!raw_req[1].cyc) begin
                    next_owner = raw_req[0].cyc ? lc3b_arb_pkg::OWNER_PORT0
                                                : lc3b_arb_pkg::OWNER_NONE;
                end
            end
            default: next_owner = lc3b_arb_pkg::OWNER_NONE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            owner <= lc3b_arb_pkg::OWNER_NONE;
        end else begin
            owner <= next_owner;
        end
    end

    // The registered request lags the raw cyc by one cycle. Qualifying it
    // with the raw cyc gives the memory a low strobe in the release cycle,
    // so it can leave its wait state before a direct hand-off.
    always_comb begin
        o_mem_req = '0;
        for (int p = 0; p < lc3b_arb_pkg::N_PORTS; p++) begin
            if (own[p]) begin
                o_mem_req     = reg_req[p];
                o_mem_req.cyc = reg_req[p].cyc & raw_req[p].cyc;
                o_mem_req.stb = reg_req[p].stb & raw_req[p].cyc;
            end
        end
    end

    for (genvar p = 0; p < lc3b_arb_pkg::N_PORTS; p++) begin : g_rsp
        assign rsp[p] = '{
            ack: own[p] & i_mem_rsp.ack,
            rty: ~(own[p] | grant[p]),  // retry unless owner or granted
            dat: own[p] ? i_mem_rsp.dat : '0
        };
    end

    assign o_rsp0 = rsp[0];
    assign o_rsp1 = rsp[1];

endmodule : cache_arbiter

// File: rtl/line_memory.sv
`timescale 1ns/1ps

module line_memory (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  lc3b_bus_pkg::wb_req_t i_req,
    output lc3b_bus_pkg::wb_rsp_t o_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,  // ready for a strobe
        ST_BUSY,  // counting down latency
        ST_WAIT   // acked, wait for stb low
    } state_e;

    state_e                               state;
    logic [lc3b_bus_pkg::MEM_CNT_W-1:0]   cnt;
    logic                                 ack_q;
    lc3b_bus_pkg::line_t                  rdat_q;
    lc3b_bus_pkg::line_t                  mem [lc3b_bus_pkg::MEM_DEPTH];
    logic [lc3b_bus_pkg::MEM_IDX_W-1:0]   idx;
    logic                                 strobe;
    logic                                 done;

    assign idx    = i_req.adr[lc3b_bus_pkg::MEM_IDX_W-1:0];  // upper bits alias
    assign strobe = i_req.cyc & i_req.stb;
    assign done   = (state == ST_BUSY) && (cnt == '0);  // access happens here

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;  // single cycle pulse
            case (state)
                ST_IDLE: begin
                    if (strobe) begin
                        state <= ST_BUSY;
                        cnt   <= lc3b_bus_pkg::MEM_CNT_LOAD;
                    end
                end
                ST_BUSY: begin
                    if (done) begin
                        state <= ST_WAIT;
                        ack_q <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (!i_req.stb) begin
                        state <= ST_IDLE;  // one ack per strobe
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request fields are held stable until ack, so sample them at the end
    always_ff @(posedge clk) begin
        if (done) begin
            rdat_q <= mem[idx];  // old contents on a write
            if (i_req.we) begin
                for (int b = 0; b < lc3b_bus_pkg::SEL_W; b++) begin
                    if (i_req.sel[b]) begin
                        mem[idx][8*b +: 8] <= i_req.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    assign o_rsp = '{
        ack: ack_q,
        rty: 1'b0,  // memory never asks for retry
        dat: rdat_q
    };

endmodule : line_memory

// File: rtl/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  lc3b_bus_pkg::wb_req_t i_req0,  // instruction cache
    input  lc3b_bus_pkg::wb_req_t i_req1,  // data cache
    output lc3b_bus_pkg::wb_rsp_t o_rsp0,
    output lc3b_bus_pkg::wb_rsp_t o_rsp1
);

    lc3b_bus_pkg::wb_req_t req0_q;
    lc3b_bus_pkg::wb_req_t req1_q;
    lc3b_bus_pkg::wb_req_t mem_req;
    lc3b_bus_pkg::wb_rsp_t mem_rsp;
    lc3b_bus_pkg::wb_rsp_t mem_rsp_q;  // back toward the arbiter

    bus_barrier #(
        .payload_t (lc3b_bus_pkg::wb_req_t)
    ) u_req0_barrier (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_d      (i_req0),
        .o_q      (req0_q)
    );

    bus_barrier #(
        .payload_t (lc3b_bus_pkg::wb_req_t)
    ) u_req1_barrier (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_d      (i_req1),
        .o_q      (req1_q)
    );

    cache_arbiter u_arbiter (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_raw_req0 (i_req0),  // ownership follows raw cyc
        .i_raw_req1 (i_req1),
        .i_reg_req0 (req0_q),
        .i_reg_req1 (req1_q),
        .i_mem_rsp  (mem_rsp_q),
        .o_mem_req  (mem_req),
        .o_rsp0     (o_rsp0),
        .o_rsp1     (o_rsp1)
    );

    line_memory u_memory (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_req    (mem_req),
        .o_rsp    (mem_rsp)
    );

    bus_barrier #(
        .payload_t (lc3b_bus_pkg::wb_rsp_t)
    ) u_rsp_barrier (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_d      (mem_rsp),
        .o_q      (mem_rsp_q)
    );

endmodule : mem_subsystem_top

// File: tests/mem_subsystem_assertions.sv
`timescale 1ns/1ps

module mem_subsystem_assertions (
    input logic                  clk,
    input logic                  i_arst_n,
    input lc3b_bus_pkg::wb_req_t i_req0,
    input lc3b_bus_pkg::wb_req_t i_req1,
    input lc3b_bus_pkg::wb_rsp_t o_rsp0,
    input lc3b_bus_pkg::wb_rsp_t o_rsp1
);

    int n_fail = 0;  // failed checks so far

    logic [lc3b_arb_pkg::N_PORTS-1:0] acks;
    logic [lc3b_arb_pkg::N_PORTS-1:0] go;  // ports not told to retry

    assign acks = {o_rsp1.ack, o_rsp0.ack};
    assign go   = ~{o_rsp1.rty, o_rsp0.rty};

    a_single_ack: assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0(acks))
    else begin
        $error("both ports acknowledged in one cycle");
        n_fail++;
    end

    a_single_owner: assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0(go))
    else begin
        $error("more than one port released from retry");
        n_fail++;
    end

    a_ack_no_rty: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(o_rsp0.ack && o_rsp0.rty) && !(o_rsp1.ack && o_rsp1.rty))
    else begin
        $error("ack and rty seen together on one port");
        n_fail++;
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_rsp0.ack |-> i_req0.cyc) and (o_rsp1.ack |-> i_req1.cyc))
    else begin
        $error("ack given to a port without cyc");
        n_fail++;
    end

    a_reset_state: assert property (@(posedge clk)
        $rose(i_arst_n) |-> (o_rsp0.rty && o_rsp1.rty && !o_rsp0.ack && !o_rsp1.ack))
    else begin
        $error("responses not in reset state when reset was released");
        n_fail++;
    end

endmodule : mem_subsystem_assertions

bind mem_subsystem_top mem_subsystem_assertions u_assertions (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_req0   (i_req0),
    .i_req1   (i_req1),
    .o_rsp0   (o_rsp0),
    .o_rsp1   (o_rsp1)
);

// File: tests/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int N_RANDOM   = 200;  // per port in the mixed test
    localparam int N_XFERS    = 16 + 5 + 3 + 2 + 16 + 2 * N_RANDOM;
    localparam int MAX_CYCLES = N_XFERS * 40 + 1000;

    // one finished transfer as seen by a master
    typedef struct packed {
        logic                port;
        logic                we;
        lc3b_bus_pkg::sel_t  sel;
        lc3b_bus_pkg::adr_t  adr;
        lc3b_bus_pkg::line_t wdat;
        lc3b_bus_pkg::line_t rdat;
    } xfer_t;

    logic                  clk;
    logic                  i_arst_n;
    lc3b_bus_pkg::wb_req_t req0;
    lc3b_bus_pkg::wb_req_t req1;
    lc3b_bus_pkg::wb_rsp_t rsp0;
    lc3b_bus_pkg::wb_rsp_t rsp1;

    lc3b_bus_pkg::line_t shadow [lc3b_bus_pkg::MEM_DEPTH];  // expected memory
    xfer_t               done_q [$];  // completions in ack order
    int                  n_queued  = 0;
    int                  n_checked = 0;
    int                  err_count = 0;
    int                  n_pass    = 0;
    int                  n_fail    = 0;
    int                  cycles    = 0;
    int                  t_ack [2];  // cycle of the last ack per port
    int                  seed      = 32'h336ba65b;
    logic                p0_done;

    mem_subsystem_top i_dut (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_req0   (req0),
        .i_req1   (req1),
        .o_rsp0   (rsp0),
        .o_rsp1   (rsp1)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles, a transfer never finished", cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // replace only the selected bytes of a line
    function automatic lc3b_bus_pkg::line_t merge_line(input lc3b_bus_pkg::line_t old_line,
                                                       input lc3b_bus_pkg::line_t wdat,
                                                       input lc3b_bus_pkg::sel_t  sel);
        lc3b_bus_pkg::line_t merged;
        merged = old_line;
        for (int b = 0; b < lc3b_bus_pkg::SEL_W; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = wdat[8*b +: 8];
            end
        end
        return merged;
    endfunction

    function automatic lc3b_bus_pkg::line_t rand_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic compare_line(input string name, input lc3b_bus_pkg::line_t got,
                                input lc3b_bus_pkg::line_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic log_completion(input xfer_t x);
        t_ack[x.port] = cycles;
        done_q.push_back(x);
        n_queued++;
    endtask

    task automatic drive_port0(input logic we, input lc3b_bus_pkg::sel_t sel,
                               input lc3b_bus_pkg::adr_t adr, input lc3b_bus_pkg::line_t wdat,
                               output lc3b_bus_pkg::line_t rdat);
        xfer_t x;
        @(posedge clk);
        req0 <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
        do begin
            @(negedge clk);
        end while (!rsp0.ack);
        rdat = rsp0.dat;
        x = '{port: 1'b0, we: we, sel: sel, adr: adr, wdat: wdat, rdat: rdat};
        log_completion(x);
        @(posedge clk);
        req0 <= '0;  // release in the cycle after ack
    endtask

    task automatic drive_port1(input logic we, input lc3b_bus_pkg::sel_t sel,
                               input lc3b_bus_pkg::adr_t adr, input lc3b_bus_pkg::line_t wdat,
                               output lc3b_bus_pkg::line_t rdat);
        xfer_t x;
        @(posedge clk);
        req1 <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
        do begin
            @(negedge clk);
        end while (!rsp1.ack);
        rdat = rsp1.dat;
        x = '{port: 1'b1, we: we, sel: sel, adr: adr, wdat: wdat, rdat: rdat};
        log_completion(x);
        @(posedge clk);
        req1 <= '0;
    endtask

    task automatic random_traffic(input int port);
        logic                we;
        lc3b_bus_pkg::sel_t  sel;
        lc3b_bus_pkg::adr_t  adr;
        lc3b_bus_pkg::line_t wdat;
        lc3b_bus_pkg::line_t rdat;
        repeat (N_RANDOM) begin
            we   = 1'($random(seed));
            sel  = 16'($random(seed));
            adr  = 12'($random(seed)) & 12'hF0F;  // lines 0..15 under any alias
            wdat = rand_line();
            if (port == 0) begin
                drive_port0(we, sel, adr, wdat, rdat);
            end else begin
                drive_port1(we, sel, adr, wdat, rdat);
            end
        end
    endtask

    task automatic wait_checked();
        wait (n_checked == n_queued);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            n_pass++;
            $display("test %s: passed", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    // apply writes to the shadow and compare reads in ack order
    initial begin : check_reads
        xfer_t x;
        int    idx;
        forever begin
            @(posedge clk);
            while (done_q.size() > 0) begin
                x   = done_q.pop_front();
                idx = int'(x.adr[lc3b_bus_pkg::MEM_IDX_W-1:0]);
                if (x.we) begin
                    shadow[idx] = merge_line(shadow[idx], x.wdat, x.sel);
                end else begin
                    compare_line($sformatf("o_rsp%0d.dat", x.port), x.rdat, shadow[idx]);
                end
                n_checked++;
            end
        end
    end

    initial begin
        lc3b_bus_pkg::line_t wd;
        lc3b_bus_pkg::line_t rd;
        lc3b_bus_pkg::adr_t  adr;
        int                  errs;

        req0     = '0;
        req1     = '0;
        i_arst_n = 1'b0;
        p0_done  = 1'b0;
        repeat (10) @(posedge clk);
        i_arst_n <= 1'b1;

        errs = err_count;
        repeat (2) @(negedge clk);
        compare_flag("o_rsp0.ack", rsp0.ack, 1'b0);
        compare_flag("o_rsp1.ack", rsp1.ack, 1'b0);
        compare_flag("o_rsp0.rty", rsp0.rty, 1'b1);
        compare_flag("o_rsp1.rty", rsp1.rty, 1'b1);
        finish_test("reset state", errs);

        errs = err_count;
        for (int i = 0; i < 8; i++) begin
            adr = 12'(i * 'h111 + 'h005);  // distinct low bytes
            drive_port0(1'b1, '1, adr, rand_line(), rd);
        end
        for (int i = 0; i < 8; i++) begin
            adr = 12'(i * 'h111 + 'h005);
            drive_port0(1'b0, '0, adr, '0, rd);
        end
        wait_checked();
        finish_test("port 0 full lines", errs);

        errs = err_count;
        repeat (4) begin
            drive_port1(1'b1, 16'($random(seed)), 12'h116, rand_line(), rd);
        end
        drive_port1(1'b0, '0, 12'h116, '0, rd);
        wait_checked();
        finish_test("port 1 byte merge", errs);

        errs = err_count;
        do begin
            @(negedge clk);
        end while (!(rsp0.rty && rsp1.rty));  // wait for the bus to go idle
        wd      = rand_line();
        p0_done = 1'b0;
        fork
            begin
                drive_port0(1'b1, '1, 12'h0C1, wd, rd);
                p0_done = 1'b1;
            end
            drive_port1(1'b0, '0, 12'h116, '0, rd);
            do begin
                @(negedge clk);
                compare_flag("o_rsp1.rty", rsp1.rty, 1'b1);  // port 0 holds the bus
            end while (!p0_done);
        join
        if (t_ack[0] >= t_ack[1]) begin
            $display("port 1 was acknowledged before port 0 after a simultaneous request");
            err_count++;
        end
        drive_port0(1'b0, '0, 12'h0C1, '0, rd);
        compare_line("o_rsp0.dat", rd, wd);
        wait_checked();
        finish_test("contention", errs);

        errs = err_count;
        wd = rand_line();
        drive_port0(1'b1, '1, 12'h0A3, wd, rd);
        drive_port1(1'b0, '0, 12'h1A3, '0, rd);  // same index in the other alias
        compare_line("o_rsp1.dat", rd, wd);
        wait_checked();
        finish_test("address alias", errs);

        errs = err_count;
        for (int i = 0; i < 16; i++) begin
            drive_port0(1'b1, '1, 12'(i), rand_line(), rd);
        end
        fork
            random_traffic(0);
            random_traffic(1);
        join
        wait_checked();
        finish_test("random mixed traffic", errs);

        if (i_dut.u_assertions.n_fail != 0) begin
            $display("bus protocol assertions failed %0d times", i_dut.u_assertions.n_fail);
        end
        $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && i_dut.u_assertions.n_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_mem_subsystem

// File: sources.f
rtl/lc3b_bus_pkg.sv
rtl/lc3b_arb_pkg.sv
rtl/bus_barrier.sv
rtl/cache_arbiter.sv
rtl/line_memory.sv
rtl/mem_subsystem_top.sv
tests/mem_subsystem_assertions.sv
tests/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: lc3b_mem_subsystem

sources:
  # packages first, then design, then verification
  - rtl/lc3b_bus_pkg.sv
  - rtl/lc3b_arb_pkg.sv
  - rtl/bus_barrier.sv
  - rtl/cache_arbiter.sv
  - rtl/line_memory.sv
  - rtl/mem_subsystem_top.sv
  - tests/mem_subsystem_assertions.sv
  - tests/tb_mem_subsystem.sv
